// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  # Packages first, then the pipeline stages and the top level
  - files:
      - common/mem_op_pkg.sv
      - common/mem_cfg_pkg.sv
      - mem_ctrl/req_arbiter.sv
      - mem_ctrl/access_check.sv
      - mem_ctrl/rsp_router.sv
      - logic/sram_bank.sv
      - logic/mem_subsys.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/mem_subsys_properties.sv
      - bench/mem_subsys_tb.sv

// ==== bench/mem_subsys_properties.sv ====
`timescale 1ns/1ps

module mem_subsys_properties
    import mem_op_pkg::*;
(
    input logic            clk,
    input logic            arst_n,
    input logic            i_credit,
    input logic            d_credit,
    input logic            i_rsp_valid,
    input logic [XLEN-1:0] i_rsp_data,
    input logic            i_rsp_err,
    input logic            d_rsp_valid,
    input logic [XLEN-1:0] d_rsp_data,
    input logic            d_rsp_err
);

    // ************************************************************************
    // Response rules
    // ************************************************************************
    i_err_data_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (i_rsp_valid && i_rsp_err) |-> (i_rsp_data == '0))
        else $error("Instruction error response with nonzero data");

    d_err_data_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (d_rsp_valid && d_rsp_err) |-> (d_rsp_data == '0))
        else $error("Data error response with nonzero data");

    one_port_per_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        !(i_rsp_valid && d_rsp_valid))
        else $error("Both ports got a response in one cycle");

    // Quiet while held in reset
    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !(i_credit || d_credit || i_rsp_valid || d_rsp_valid))
        else $error("Credit or response pulse during reset");

endmodule

bind mem_subsys mem_subsys_properties mem_subsys_properties_inst (.*);

// ==== bench/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb
    import mem_op_pkg::*;
;

    localparam int unsigned MEM_WORDS   = 256;
    localparam int unsigned CREDITS     = 4;
    localparam int unsigned RAND_CYCLES = 400;
    localparam int unsigned MAX_REQ     = 142 + 2 * RAND_CYCLES;   // Directed plus two per cycle

    logic            clk = 1'b0;
    logic            arst_n;
    logic            i_req_valid;
    logic [XLEN-1:0] i_req_addr;
    logic            i_credit;
    logic            i_rsp_valid;
    logic [XLEN-1:0] i_rsp_data;
    logic            i_rsp_err;
    logic            d_req_valid;
    mem_op_e         d_req_op;
    logic [XLEN-1:0] d_req_addr;
    logic [XLEN-1:0] d_req_wdata;
    logic            d_credit;
    logic            d_rsp_valid;
    logic [XLEN-1:0] d_rsp_data;
    logic            d_rsp_err;

    logic [XLEN-1:0] ref_mem [MEM_WORDS];
    logic [XLEN:0]   i_exp [$];               // {err, data}
    logic [XLEN:0]   d_exp [$];
    logic [XLEN:0]   head;
    logic [15:0]     lfsr_state;
    int              i_cred;
    int              d_cred;
    int              check_errors = 0;
    int              proto_errors = 0;
    int              checked = 0;
    logic            issued_any = 1'b0;

    mem_subsys #(
        .MEM_WORDS(MEM_WORDS),
        .CREDITS(CREDITS)
    ) mem_subsys_inst (.*);

    always #10 clk = ~clk;

    // ************************************************************************
    // Random source and reference model
    // ************************************************************************
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_op_e pick_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return OP_LB;
            3'd1:    return OP_LH;
            3'd2:    return OP_LW;
            3'd3:    return OP_LBU;
            3'd4:    return OP_LHU;
            3'd5:    return OP_SB;
            3'd6:    return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    // Stores also write the model
    function automatic logic [XLEN:0] reference_access(input mem_op_e op,
                                                      input logic [31:0] addr,
                                                      input logic [31:0] wdata);
        int unsigned nbytes;
        int unsigned idx;
        int unsigned lane;
        logic [31:0] sh;
        case (op)
            OP_LB, OP_LBU, OP_SB: nbytes = 1;
            OP_LH, OP_LHU, OP_SH: nbytes = 2;
            default:              nbytes = 4;
        endcase
        if (((addr % nbytes) != 0) || (addr >= MEM_WORDS * 4)) begin
            return {1'b1, 32'h0};
        end
        idx  = addr / 4;
        lane = addr % 4;
        sh   = ref_mem[idx] >> (8 * lane);
        case (op)
            OP_LB:  return {1'b0, {24{sh[7]}}, sh[7:0]};
            OP_LBU: return {1'b0, 24'h0, sh[7:0]};
            OP_LH:  return {1'b0, {16{sh[15]}}, sh[15:0]};
            OP_LHU: return {1'b0, 16'h0, sh[15:0]};
            OP_LW:  return {1'b0, sh};
            default: begin
                for (int b = 0; b < nbytes; b++) begin
                    ref_mem[idx][8*(lane+b) +: 8] = wdata[8*b +: 8];
                end
                return {1'b0, 32'h0};       // Store ack
            end
        endcase
    endfunction

    // Each port issues only with a credit in hand
    task automatic drive_cycle(input logic i_go, input logic [31:0] i_addr,
                               input logic d_go, input mem_op_e d_op,
                               input logic [31:0] d_addr, input logic [31:0] d_wdata,
                               output logic i_done, output logic d_done);
        @(posedge clk);
        i_done = i_go && (i_cred > 0);
        d_done = d_go && (d_cred > 0);
        i_req_valid <= i_done;
        i_req_addr  <= i_addr;
        d_req_valid <= d_done;
        d_req_op    <= d_op;
        d_req_addr  <= d_addr;
        d_req_wdata <= d_wdata;
        if (i_done) begin
            i_cred = i_cred - 1;
            i_exp.push_back(reference_access(OP_LW, i_addr, '0));
        end
        if (d_done) begin
            d_cred = d_cred - 1;
            d_exp.push_back(reference_access(d_op, d_addr, d_wdata));
        end
        if (i_done || d_done) issued_any = 1'b1;
    endtask

    task automatic idle_cycles(input int unsigned n);
        logic i_done;
        logic d_done;
        repeat (n) drive_cycle(1'b0, '0, 1'b0, OP_LW, '0, '0, i_done, d_done);
    endtask

    task automatic d_access(input mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        logic i_done;
        logic d_done;
        d_done = 1'b0;
        while (!d_done) drive_cycle(1'b0, '0, 1'b1, op, addr, wdata, i_done, d_done);
    endtask

    task automatic i_fetch(input logic [31:0] addr);
        logic i_done;
        logic d_done;
        i_done = 1'b0;
        while (!i_done) drive_cycle(1'b1, addr, 1'b0, OP_LW, '0, '0, i_done, d_done);
    endtask

    task automatic drain_and_check_credits();
        while ((i_exp.size() != 0) || (d_exp.size() != 0)) idle_cycles(1);
        idle_cycles(3);
        if ((i_cred != CREDITS) || (d_cred != CREDITS)) begin
            check_errors++;
            $display("CHECK FAILED at %0t: credits i=%0d d=%0d after drain, expected %0d",
                     $time, i_cred, d_cred, CREDITS);
        end
    endtask

    // ************************************************************************
    // Credit tracking and response compare
    // ************************************************************************
    always @(negedge clk) begin
        if (i_credit === 1'b1) i_cred = i_cred + 1;
        if (d_credit === 1'b1) d_cred = d_cred + 1;
        if ((i_cred > CREDITS) || (d_cred > CREDITS)) begin
            proto_errors++;
            $display("More credits returned than requests made at %0t", $time);
        end
        if (!issued_any && ((i_credit === 1'b1) || (d_credit === 1'b1) ||
                            (i_rsp_valid === 1'b1) || (d_rsp_valid === 1'b1))) begin
            proto_errors++;
            $display("Credit or response pulse before any request at %0t", $time);
        end
        if (i_rsp_valid === 1'b1) begin
            if (i_exp.size() == 0) begin
                proto_errors++;
                $display("Instruction response at %0t with no request outstanding", $time);
            end else begin
                head = i_exp.pop_front();
                checked++;
                if ({i_rsp_err, i_rsp_data} !== head) begin
                    check_errors++;
                    $display("CHECK FAILED at %0t: fetch err/data %0b/%h, expected %0b/%h",
                             $time, i_rsp_err, i_rsp_data, head[XLEN], head[XLEN-1:0]);
                end
            end
        end
        if (d_rsp_valid === 1'b1) begin
            if (d_exp.size() == 0) begin
                proto_errors++;
                $display("Data response at %0t with no request outstanding", $time);
            end else begin
                head = d_exp.pop_front();
                checked++;
                if ({d_rsp_err, d_rsp_data} !== head) begin
                    check_errors++;
                    $display("CHECK FAILED at %0t: data err/data %0b/%h, expected %0b/%h",
                             $time, d_rsp_err, d_rsp_data, head[XLEN], head[XLEN-1:0]);
                end
            end
        end
    end

    initial begin
        repeat (MAX_REQ * 20 + 200) @(posedge clk);
        $display("Timeout: responses or credits never came back, %0d errors so far",
                 check_errors + proto_errors);
        $display("Verification failed");
        $finish;
    end

    // ************************************************************************
    // Test sequence
    // ************************************************************************
    initial begin
        logic [31:0] data;
        logic [31:0] i_addr;
        logic [31:0] d_addr;
        logic        i_go;
        logic        d_go;
        logic        i_done;
        logic        d_done;
        mem_op_e     op;
        lfsr_state  = 16'd46;
        i_cred      = CREDITS;
        d_cred      = CREDITS;
        arst_n      = 1'b1;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        d_req_valid = 1'b0;
        d_req_op    = OP_LW;
        d_req_addr  = '0;
        d_req_wdata = '0;
        arst_n     <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        idle_cycles(6);                              // Outputs must stay quiet

        // Fetch window 0..15 and data window 32..47
        for (int w = 0; w < 48; w++) d_access(OP_SW, 4 * w, take_bits(32));
        for (int w = 0; w < 48; w++) d_access(OP_LW, 4 * w, '0);

        for (int l = 0; l < 4; l++) begin
            data = take_bits(32);
            if (l[0]) data[7] = 1'b1;
            d_access(OP_SB, 4 * 33 + l, data);
            d_access(OP_LB, 4 * 33 + l, '0);
            d_access(OP_LBU, 4 * 33 + l, '0);
        end
        for (int l = 0; l < 4; l += 2) begin
            data = take_bits(32);
            if (l == 2) data[15] = 1'b1;
            d_access(OP_SH, 4 * 34 + l, data);
            d_access(OP_LH, 4 * 34 + l, '0);
            d_access(OP_LHU, 4 * 34 + l, '0);
        end
        d_access(OP_LW, 4 * 33, '0);
        d_access(OP_LW, 4 * 34, '0);

        // Rejected accesses leave word 35 untouched
        d_access(OP_LH, 4 * 35 + 1, '0);
        d_access(OP_LW, 4 * 35 + 2, '0);
        d_access(OP_SW, 4 * 35 + 1, 32'hdead_beef);
        d_access(OP_SH, 4 * 35 + 3, 32'h0000_a5a5);
        d_access(OP_LW, 4 * 35, '0);
        d_access(OP_LW, MEM_WORDS * 4, '0);
        d_access(OP_SB, MEM_WORDS * 4 + 8, 32'h0000_00ff);
        d_access(OP_LBU, 32'h1000_0000, '0);

        for (int w = 0; w < 16; w++) i_fetch(4 * w);
        i_fetch(4 * 3 + 2);
        i_fetch(MEM_WORDS * 4);
        drain_and_check_credits();

        // ********************************************************************
        // Concurrent random traffic
        // ********************************************************************
        for (int c = 0; c < RAND_CYCLES; c++) begin
            i_go   = take_bits(1);
            i_addr = 4 * take_bits(4);
            if (take_bits(3) == 0) i_addr = i_addr | take_bits(2);
            d_go   = take_bits(1);
            op     = pick_op(take_bits(3));
            d_addr = 4 * (32 + take_bits(4));
            d_addr = d_addr | take_bits(2);
            if (take_bits(4) == 0) d_addr = MEM_WORDS * 4 + take_bits(6);
            data   = take_bits(32);
            drive_cycle(i_go, i_addr, d_go, op, d_addr, data, i_done, d_done);
        end
        drain_and_check_credits();

        $display("Checked %0d responses: %0d value errors, %0d protocol errors",
                 checked, check_errors, proto_errors);
        if ((check_errors == 0) && (proto_errors == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== common/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

    // Response owner tag
    localparam int unsigned PORT_W = 1;

    typedef enum logic [PORT_W-1:0] {
        PORT_I = 1'b0,
        PORT_D = 1'b1
    } port_e;

    localparam int unsigned NUM_PORTS = 2;

    // Up to 8 credits per port
    localparam int unsigned MAX_CREDITS = 8;
    localparam int unsigned CREDIT_W    = $clog2(MAX_CREDITS + 1);

endpackage

// ==== common/mem_op_pkg.sv ====
package mem_op_pkg;

    // Data and address width
    localparam int unsigned XLEN   = 32;
    localparam int unsigned BYTE_W = 8;
    localparam int unsigned MASK_W = XLEN / BYTE_W;

    // Access sizes as log2 of the byte count
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    // Low bits follow funct3, bit 3 marks a store
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } mem_op_e;

    function automatic logic op_is_store(input mem_op_e op);
        case (op)
            OP_SB, OP_SH, OP_SW: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    function automatic logic [1:0] op_size(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SIZE_B;
            OP_LH, OP_LHU, OP_SH: return SIZE_H;
            default:              return SIZE_W;
        endcase
    endfunction

endpackage

// ==== logic/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 256,
    parameter int unsigned CREDITS   = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            i_req_valid,
    input  logic [XLEN-1:0] i_req_addr,
    output logic            i_credit,
    output logic            i_rsp_valid,
    output logic [XLEN-1:0] i_rsp_data,
    output logic            i_rsp_err,
    input  logic            d_req_valid,
    input  mem_op_e         d_req_op,
    input  logic [XLEN-1:0] d_req_addr,
    input  logic [XLEN-1:0] d_req_wdata,
    output logic            d_credit,
    output logic            d_rsp_valid,
    output logic [XLEN-1:0] d_rsp_data,
    output logic            d_rsp_err
);

    localparam int unsigned WORD_W = $clog2(MEM_WORDS);

    // Issue stage
    logic            iss_valid;
    port_e           iss_port;
    mem_op_e         iss_op;
    logic [XLEN-1:0] iss_addr;
    logic [XLEN-1:0] iss_wdata;

    // Checked access
    logic              acc_valid;
    port_e             acc_port;
    mem_op_e           acc_op;
    logic [WORD_W-1:0] acc_word;
    logic [1:0]        acc_lane;
    logic [MASK_W-1:0] acc_mask;
    logic [XLEN-1:0]   acc_wdata;
    logic              acc_err;

    logic [XLEN-1:0] sram_rdata;

    // ************************************************************************
    // Pipeline stages
    // ************************************************************************
    req_arbiter #(
        .CREDITS(CREDITS)
    ) req_arbiter_inst (.*);

    access_check #(
        .MEM_WORDS(MEM_WORDS)
    ) access_check_inst (.*);

    sram_bank #(
        .MEM_WORDS(MEM_WORDS)
    ) sram_bank_inst (.*);

    rsp_router rsp_router_inst (.*);

endmodule

// ==== logic/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank
    import mem_op_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         acc_valid,
    input  logic                         acc_err,
    input  mem_op_e                      acc_op,
    input  logic [$clog2(MEM_WORDS)-1:0] acc_word,
    input  logic [MASK_W-1:0]            acc_mask,
    input  logic [XLEN-1:0]              acc_wdata,
    output logic [XLEN-1:0]              sram_rdata
);

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic            en;
    logic            wr;

    assign en = acc_valid && !acc_err;          // Rejected accesses stay off
    assign wr = op_is_store(acc_op);

    // ************************************************************************
    // Byte-masked write, registered read
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (en && wr) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (acc_mask[b]) begin
                    mem[acc_word][b*BYTE_W +: BYTE_W] <= acc_wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && !wr) begin
            sram_rdata <= mem[acc_word];
        end
    end

endmodule

// ==== mem_ctrl/access_check.sv ====
`timescale 1ns/1ps

module access_check
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         iss_valid,
    input  port_e                        iss_port,
    input  mem_op_e                      iss_op,
    input  logic [XLEN-1:0]              iss_addr,
    input  logic [XLEN-1:0]              iss_wdata,
    output logic                         acc_valid,
    output port_e                        acc_port,
    output mem_op_e                      acc_op,
    output logic [$clog2(MEM_WORDS)-1:0] acc_word,
    output logic [1:0]                   acc_lane,
    output logic [MASK_W-1:0]            acc_mask,
    output logic [XLEN-1:0]              acc_wdata,
    output logic                         acc_err
);

    localparam int unsigned WORD_W = $clog2(MEM_WORDS);

    logic [1:0]        size;
    logic [1:0]        lane;
    logic              misalign;
    logic              out_of_range;
    logic [MASK_W-1:0] base_mask;
    logic [MASK_W-1:0] mask;

    // ************************************************************************
    // Alignment and range
    // ************************************************************************
    always_comb begin
        size         = op_size(iss_op);
        lane         = iss_addr[1:0];
        misalign     = ((size == SIZE_H) && lane[0]) || ((size == SIZE_W) && (lane != 2'b00));
        out_of_range = iss_addr[XLEN-1:2] >= (XLEN-2)'(MEM_WORDS);
    end

    // Store byte mask from size and lane
    always_comb begin
        case (size)
            SIZE_B:  base_mask = 4'b0001;
            SIZE_H:  base_mask = 4'b0011;
            default: base_mask = 4'b1111;
        endcase
        mask = op_is_store(iss_op) ? (base_mask << lane) : '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        acc_port  <= iss_port;
        acc_op    <= iss_op;
        acc_word  <= iss_addr[WORD_W+1:2];
        acc_lane  <= lane;
        acc_mask  <= mask;
        acc_wdata <= iss_wdata << (lane * BYTE_W);     // Data onto its lanes
        acc_err   <= misalign || out_of_range;
    end

endmodule

// ==== mem_ctrl/req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;
#(
    parameter int unsigned CREDITS = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            i_req_valid,
    input  logic [XLEN-1:0] i_req_addr,
    input  logic            d_req_valid,
    input  mem_op_e         d_req_op,
    input  logic [XLEN-1:0] d_req_addr,
    input  logic [XLEN-1:0] d_req_wdata,
    output logic            i_credit,
    output logic            d_credit,
    output logic            iss_valid,
    output port_e           iss_port,
    output mem_op_e         iss_op,
    output logic [XLEN-1:0] iss_addr,
    output logic [XLEN-1:0] iss_wdata
);

    localparam int unsigned PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;

    // Entry storage, instruction entries imply OP_LW
    logic [XLEN-1:0] i_addr_mem  [CREDITS];
    mem_op_e         d_op_mem    [CREDITS];
    logic [XLEN-1:0] d_addr_mem  [CREDITS];
    logic [XLEN-1:0] d_wdata_mem [CREDITS];

    logic [NUM_PORTS-1:0][PTR_W-1:0]    wr_ptr;
    logic [NUM_PORTS-1:0][PTR_W-1:0]    rd_ptr;
    logic [NUM_PORTS-1:0][CREDIT_W-1:0] cnt;
    logic [NUM_PORTS-1:0]               push;
    logic [NUM_PORTS-1:0]               pop;
    logic  grant_i;
    logic  grant_d;
    port_e last_port;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = {d_req_valid, i_req_valid};
    assign pop  = {grant_d, grant_i};

    // ************************************************************************
    // Round-robin selection
    // ************************************************************************
    assign grant_d = (cnt[PORT_D] != '0) && ((cnt[PORT_I] == '0) || (last_port == PORT_I));
    assign grant_i = (cnt[PORT_I] != '0) && !grant_d;

    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            i_addr_mem[wr_ptr[PORT_I]] <= i_req_addr;
        end
        if (d_req_valid) begin
            d_op_mem[wr_ptr[PORT_D]]    <= d_req_op;
            d_addr_mem[wr_ptr[PORT_D]]  <= d_req_addr;
            d_wdata_mem[wr_ptr[PORT_D]] <= d_req_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (push[p]) wr_ptr[p] <= next_ptr(wr_ptr[p]);
                if (pop[p]) rd_ptr[p] <= next_ptr(rd_ptr[p]);
                if (push[p] && !pop[p]) begin
                    cnt[p] <= cnt[p] + CREDIT_W'(1);
                end else if (pop[p] && !push[p]) begin
                    cnt[p] <= cnt[p] - CREDIT_W'(1);
                end
            end
        end
    end

    // ************************************************************************
    // Issue register and credit return
    // ************************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
            i_credit  <= 1'b0;
            d_credit  <= 1'b0;
            last_port <= PORT_D;                   // First tie goes to PORT_I
        end else begin
            iss_valid <= grant_i || grant_d;
            i_credit  <= grant_i;                  // Entry just left the buffer
            d_credit  <= grant_d;
            if (grant_i) last_port <= PORT_I;
            if (grant_d) last_port <= PORT_D;
        end
    end

    always_ff @(posedge clk) begin
        iss_port  <= grant_d ? PORT_D : PORT_I;
        iss_op    <= grant_d ? d_op_mem[rd_ptr[PORT_D]] : OP_LW;
        iss_addr  <= grant_d ? d_addr_mem[rd_ptr[PORT_D]] : i_addr_mem[rd_ptr[PORT_I]];
        iss_wdata <= grant_d ? d_wdata_mem[rd_ptr[PORT_D]] : '0;
    end

endmodule

// ==== mem_ctrl/rsp_router.sv ====
`timescale 1ns/1ps

module rsp_router
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            acc_valid,
    input  port_e           acc_port,
    input  mem_op_e         acc_op,
    input  logic [1:0]      acc_lane,
    input  logic            acc_err,
    input  logic [XLEN-1:0] sram_rdata,
    output logic            i_rsp_valid,
    output logic [XLEN-1:0] i_rsp_data,
    output logic            i_rsp_err,
    output logic            d_rsp_valid,
    output logic [XLEN-1:0] d_rsp_data,
    output logic            d_rsp_err
);

    // Metadata lined up with the SRAM read
    logic       dly_valid;
    port_e      dly_port;
    mem_op_e    dly_op;
    logic [1:0] dly_lane;
    logic       dly_err;

    logic [XLEN-1:0] lane_data;
    logic [XLEN-1:0] rsp_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dly_valid <= 1'b0;
        end else begin
            dly_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        dly_port <= acc_port;
        dly_op   <= acc_op;
        dly_lane <= acc_lane;
        dly_err  <= acc_err;
    end

    // ************************************************************************
    // Lane select and extension
    // ************************************************************************
    always_comb begin
        lane_data = sram_rdata >> (dly_lane * BYTE_W);
        case (dly_op)
            OP_LB:   rsp_data = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
            OP_LBU:  rsp_data = {{(XLEN-8){1'b0}}, lane_data[7:0]};
            OP_LH:   rsp_data = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
            OP_LHU:  rsp_data = {{(XLEN-16){1'b0}}, lane_data[15:0]};
            OP_LW:   rsp_data = lane_data;
            default: rsp_data = '0;                 // Stores
        endcase
        if (dly_err) rsp_data = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            i_rsp_valid <= 1'b0;
            i_rsp_data  <= '0;
            i_rsp_err   <= 1'b0;
            d_rsp_valid <= 1'b0;
            d_rsp_data  <= '0;
            d_rsp_err   <= 1'b0;
        end else begin
            i_rsp_valid <= dly_valid && (dly_port == PORT_I);
            d_rsp_valid <= dly_valid && (dly_port == PORT_D);
            if (dly_valid && (dly_port == PORT_I)) begin
                i_rsp_data <= rsp_data;
                i_rsp_err  <= dly_err;
            end
            if (dly_valid && (dly_port == PORT_D)) begin
                d_rsp_data <= rsp_data;
                d_rsp_err  <= dly_err;
            end
        end
    end

endmodule

// ==== src.f ====
common/mem_op_pkg.sv
common/mem_cfg_pkg.sv
mem_ctrl/req_arbiter.sv
mem_ctrl/access_check.sv
mem_ctrl/rsp_router.sv
logic/sram_bank.sv
logic/mem_subsys.sv
bench/mem_subsys_properties.sv
bench/mem_subsys_tb.sv
